/* Bender.yml */
package:
  name: door_lock

sources:
  - hdl/lock_types_pkg.sv
  - hdl/lock_regs_pkg.sv
  - hdl/button_debounce.sv
  - hdl/lock_config_regs.sv
  - hdl/code_checker.sv
  - hdl/door_fsm.sv
  - hdl/door_lock_top.sv
  - target: test
    files:
      - tests/tb_door_lock.sv

/* files.f */
hdl/lock_types_pkg.sv
hdl/lock_regs_pkg.sv
hdl/button_debounce.sv
hdl/lock_config_regs.sv
hdl/code_checker.sv
hdl/door_fsm.sv
hdl/door_lock_top.sv
tests/tb_door_lock.sv

/* hdl/button_debounce.sv */
`timescale 1ns/1ns

module button_debounce #(
    parameter int DEBOUNCE_CYCLES = 100
) (
    input  logic clk,
    input  logic rst,
    input  logic button,
    output logic btn_pulse
);

    localparam int CNT_W = $clog2(DEBOUNCE_CYCLES + 1);

    logic [CNT_W-1:0] hold_cnt;         // Consecutive high cycles, saturates

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            hold_cnt  <= '0;
            btn_pulse <= 1'b0;
        end else if (!button) begin
            // Release re-arms the detector
            hold_cnt  <= '0;
            btn_pulse <= 1'b0;
        end else if (hold_cnt < DEBOUNCE_CYCLES) begin
            hold_cnt  <= hold_cnt + 1'b1;
            btn_pulse <= (hold_cnt == CNT_W'(DEBOUNCE_CYCLES - 1));
        end else begin
            btn_pulse <= 1'b0;          // Still held, no repeat
        end
    end

    a_single_pulse: assert property (
        @(posedge clk) disable iff (rst)
        btn_pulse |=> !btn_pulse
    );

endmodule

/* hdl/code_checker.sv */
`timescale 1ns/1ns

module code_checker (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  check_start,
    input  lock_types_pkg::code_t check_code,
    input  lock_types_pkg::code_t user_codes [lock_types_pkg::USER_SLOTS],
    output logic                  check_done,
    output logic                  check_match
);

    import lock_types_pkg::*;
    import lock_regs_pkg::*;

    localparam int IDX_W = $clog2(USER_SLOTS);

    logic             busy;
    logic [IDX_W-1:0] slot_idx;         // Slot under comparison
    code_t            code_q;           // Entered code, held during the scan
    logic             hit;
    logic             last_slot;

    assign hit       = (user_codes[slot_idx] == code_q) && (user_codes[slot_idx] != EMPTY_CODE);
    assign last_slot = slot_idx == IDX_W'(USER_SLOTS - 1);

    // Early exit on the first match
    assign check_done  = busy && (hit || last_slot);
    assign check_match = busy && hit;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy     <= 1'b0;
            slot_idx <= '0;
        end else if (check_start) begin
            busy     <= 1'b1;
            slot_idx <= '0;
        end else if (check_done) begin
            busy <= 1'b0;
        end else if (busy) begin
            slot_idx <= slot_idx + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (check_start) begin
            code_q <= check_code;
        end
    end

    // FSM must wait for the result before starting again
    a_no_start_busy: assert property (
        @(posedge clk) disable iff (rst)
        check_start |-> !busy
    );

endmodule

/* hdl/door_fsm.sv */
`timescale 1ns/1ns

module door_fsm #(
    parameter int BLOCK_CYCLES    = 30000,
    parameter int BIP_TICK_CYCLES = 1000
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     door_sensor,
    input  logic                     btn_pulse,
    input  logic                     code_valid,
    input  lock_types_pkg::code_t    code_in,
    input  logic                     check_done,
    input  logic                     check_match,
    input  logic [7:0]               bip_time,
    output logic                     check_start,
    output lock_types_pkg::code_t    check_code,
    output logic                     lock_bolt,
    output logic                     keypad_en,
    output logic                     bip,
    output lock_types_pkg::display_t display
);

    import lock_types_pkg::*;

    localparam int ATT_W  = $clog2(MAX_ATTEMPTS + 1);
    localparam int BLK_W  = $clog2(BLOCK_CYCLES + 1);
    localparam int OPEN_W = 8 + $clog2(BIP_TICK_CYCLES + 1);    // Holds 255 ticks

    door_state_e       state;
    door_state_e       next_state;
    logic [ATT_W-1:0]  attempts;        // Failed codes since the last success
    logic [BLK_W-1:0]  block_cnt;
    logic [OPEN_W-1:0] open_cnt;        // Cycles spent in OPEN, saturates
    logic [OPEN_W-1:0] bip_limit;
    logic              key_timeout;
    logic              key_blank;
    logic              block_done;

    assign key_timeout = code_in[0] == DIGIT_TIMEOUT;
    assign key_blank   = code_in[0] == DIGIT_BLANK;
    assign block_done  = block_cnt == BLK_W'(BLOCK_CYCLES - 1);
    assign bip_limit   = OPEN_W'(bip_time) * OPEN_W'(BIP_TICK_CYCLES);

    // Button wins over a normal code arriving in the same cycle
    assign check_start = (state == CLOSED) && code_valid && !key_timeout && !key_blank
                         && !btn_pulse;
    assign check_code  = code_in;

    always_comb begin
        next_state = state;
        case (state)
            INIT: begin
                if (!door_sensor) next_state = CLOSED;
            end
            CLOSED: begin
                if (code_valid && key_timeout) begin
                    next_state = TIMEOUT_BIP;
                end else if (btn_pulse) begin
                    next_state = AJAR;
                end else if (check_start) begin
                    next_state = CHECKING;
                end
            end
            CHECKING: begin
                if (check_done) next_state = check_match ? AJAR : CODE_ERROR;
            end
            CODE_ERROR: begin
                // Count not yet updated here, so look one ahead
                if (attempts + 1'b1 >= MAX_ATTEMPTS) begin
                    next_state = BLOCKED;
                end else begin
                    next_state = CLOSED;
                end
            end
            BLOCKED: begin
                if (block_done) next_state = CLOSED;
            end
            AJAR: begin
                if (door_sensor) begin
                    next_state = OPEN;
                end else if (btn_pulse) begin
                    next_state = CLOSED;
                end
            end
            OPEN: begin
                if (!door_sensor) next_state = AJAR;
            end
            TIMEOUT_BIP: next_state = CLOSED;
            default:     next_state = INIT;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= INIT;
            attempts  <= '0;
            block_cnt <= '0;
            open_cnt  <= '0;
        end else begin
            state <= next_state;

            case (state)
                CODE_ERROR: attempts <= attempts + 1'b1;
                CHECKING: begin
                    if (check_done && check_match) attempts <= '0;
                end
                BLOCKED: begin
                    if (block_done) attempts <= '0;     // Fresh start after lockout
                end
                default: ;
            endcase

            block_cnt <= (state == BLOCKED) ? block_cnt + 1'b1 : '0;

            if (state != OPEN) begin
                open_cnt <= '0;
            end else if (open_cnt < bip_limit) begin
                open_cnt <= open_cnt + 1'b1;
            end
        end
    end

    always_comb begin
        lock_bolt = state inside {CLOSED, CHECKING, CODE_ERROR, BLOCKED, TIMEOUT_BIP};
        keypad_en = state inside {CLOSED, CHECKING};
        bip       = (state == TIMEOUT_BIP) || ((state == OPEN) && (open_cnt >= bip_limit));

        // One A per failed attempt, from the left digit
        for (int i = 0; i < DISPLAY_DIGITS; i++) begin
            if ((state == BLOCKED) || (i < attempts)) begin
                display[i] = DIGIT_ERR;
            end else begin
                display[i] = DIGIT_BLANK;
            end
        end
    end

    a_attempts_max: assert property (
        @(posedge clk) disable iff (rst)
        attempts <= ATT_W'(MAX_ATTEMPTS)
    );

    // Checker answers within one scan of all slots
    a_check_answer: assert property (
        @(posedge clk) disable iff (rst)
        check_start |-> ##[1:USER_SLOTS] check_done
    );

endmodule

/* hdl/door_lock_top.sv */
`timescale 1ns/1ns

module door_lock_top #(
    parameter int DEBOUNCE_CYCLES = 100,
    parameter int BLOCK_CYCLES    = 30000,
    parameter int BIP_TICK_CYCLES = 1000
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     door_sensor,       // High when open
    input  logic                     inside_button,
    input  logic                     code_valid,
    input  lock_types_pkg::code_t    code_in,
    input  logic                     wb_cyc,
    input  logic                     wb_stb,
    input  logic                     wb_we,
    input  logic [2:0]               wb_adr,
    input  logic [31:0]              wb_dat_w,
    output logic [31:0]              wb_dat_r,
    output logic                     wb_ack,
    output logic                     lock_bolt,
    output logic                     keypad_en,
    output logic                     bip,
    output lock_types_pkg::display_t display
);

    import lock_types_pkg::*;

    logic       btn_pulse;
    code_t      user_codes [USER_SLOTS];
    logic [7:0] bip_time;
    logic       check_start;
    code_t      check_code;
    logic       check_done;
    logic       check_match;

    button_debounce #(
        .DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)
    ) i_debounce (
        .clk      (clk),
        .rst      (rst),
        .button   (inside_button),
        .btn_pulse(btn_pulse)
    );

    lock_config_regs i_regs (
        .clk       (clk),
        .rst       (rst),
        .wb_cyc    (wb_cyc),
        .wb_stb    (wb_stb),
        .wb_we     (wb_we),
        .wb_adr    (wb_adr),
        .wb_dat_w  (wb_dat_w),
        .wb_dat_r  (wb_dat_r),
        .wb_ack    (wb_ack),
        .user_codes(user_codes),
        .bip_time  (bip_time)
    );

    code_checker i_checker (
        .clk        (clk),
        .rst        (rst),
        .check_start(check_start),
        .check_code (check_code),
        .user_codes (user_codes),
        .check_done (check_done),
        .check_match(check_match)
    );

    door_fsm #(
        .BLOCK_CYCLES   (BLOCK_CYCLES),
        .BIP_TICK_CYCLES(BIP_TICK_CYCLES)
    ) i_fsm (
        .clk        (clk),
        .rst        (rst),
        .door_sensor(door_sensor),
        .btn_pulse  (btn_pulse),
        .code_valid (code_valid),
        .code_in    (code_in),
        .check_done (check_done),
        .check_match(check_match),
        .bip_time   (bip_time),
        .check_start(check_start),
        .check_code (check_code),
        .lock_bolt  (lock_bolt),
        .keypad_en  (keypad_en),
        .bip        (bip),
        .display    (display)
    );

endmodule

/* hdl/lock_config_regs.sv */
`timescale 1ns/1ns

module lock_config_regs (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  wb_cyc,
    input  logic                  wb_stb,
    input  logic                  wb_we,
    input  logic [2:0]            wb_adr,
    input  logic [31:0]           wb_dat_w,
    output logic [31:0]           wb_dat_r,
    output logic                  wb_ack,
    output lock_types_pkg::code_t user_codes [lock_types_pkg::USER_SLOTS],
    output logic [7:0]            bip_time
);

    import lock_types_pkg::*;
    import lock_regs_pkg::*;

    reg_addr_e addr;
    logic      req;                     // New cycle, not yet acknowledged

    assign addr = reg_addr_e'(wb_adr);
    assign req  = wb_cyc && wb_stb && !wb_ack;

    // Ack for one cycle, writes land on the same edge
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wb_ack   <= 1'b0;
            bip_time <= BIP_TIME_RESET;
            for (int i = 0; i < USER_SLOTS; i++) begin
                user_codes[i] <= EMPTY_CODE;
            end
        end else begin
            wb_ack <= req;
            if (req && wb_we) begin
                case (addr)
                    REG_CODE0, REG_CODE1, REG_CODE2, REG_CODE3: begin
                        user_codes[wb_adr[1:0]] <= wb_dat_w;
                    end
                    REG_BIP_TIME: bip_time <= wb_dat_w[7:0];
                    default: ;          // ID and holes ignore writes
                endcase
            end
        end
    end

    // Read data sits in the register while ack is high
    always_ff @(posedge clk) begin
        if (req && !wb_we) begin
            case (addr)
                REG_CODE0, REG_CODE1, REG_CODE2, REG_CODE3: begin
                    wb_dat_r <= user_codes[wb_adr[1:0]];
                end
                REG_BIP_TIME: wb_dat_r <= {24'd0, bip_time};
                REG_ID:       wb_dat_r <= LOCK_ID;
                default:      wb_dat_r <= '0;
            endcase
        end
    end

    a_ack_one_cycle: assert property (
        @(posedge clk) disable iff (rst)
        wb_ack |=> !wb_ack
    );

endmodule

/* hdl/lock_regs_pkg.sv */
package lock_regs_pkg;

    import lock_types_pkg::*;

    // Word addresses of the Wishbone register block
    typedef enum logic [2:0] {
        REG_CODE0    = 3'd0,
        REG_CODE1    = 3'd1,
        REG_CODE2    = 3'd2,
        REG_CODE3    = 3'd3,
        REG_BIP_TIME = 3'd4,            // Low 8 bits only
        REG_ID       = 3'd5             // Read only
    } reg_addr_e;

    // Slot holding this value never matches
    parameter code_t EMPTY_CODE = {CODE_DIGITS{DIGIT_NONE}};

    // Open-door beep delay in units of BIP_TICK_CYCLES
    parameter logic [7:0] BIP_TIME_RESET = 8'd5;

    parameter logic [31:0] LOCK_ID = 32'h4C4B_0001;

endpackage

/* hdl/lock_types_pkg.sv */
package lock_types_pkg;

    // Sizing
    parameter int CODE_DIGITS    = 8;
    parameter int USER_SLOTS     = 4;
    parameter int DISPLAY_DIGITS = 6;
    parameter int MAX_ATTEMPTS   = 5;   // Failures before the keypad is blocked

    // Keypad and display digits with a special meaning
    typedef enum logic [3:0] {
        DIGIT_ERR     = 4'hA,           // Failure mark on the display
        DIGIT_BLANK   = 4'hB,
        DIGIT_TIMEOUT = 4'hE,           // Keypad gave up waiting for keys
        DIGIT_NONE    = 4'hF            // Unused code position
    } digit_e;

    // Digit 0 is the first key pressed
    typedef logic [CODE_DIGITS-1:0][3:0] code_t;

    typedef logic [DISPLAY_DIGITS-1:0][3:0] display_t;

    typedef enum logic [2:0] {
        INIT,                           // Waits for the door to be shut
        CLOSED,                         // Bolt thrown
        CHECKING,                       // Code compare in progress
        CODE_ERROR,                     // One cycle, counts the failure
        BLOCKED,                        // Keypad locked out
        AJAR,                           // Bolt retracted, door in frame
        OPEN,
        TIMEOUT_BIP                     // One cycle beep
    } door_state_e;

endpackage

/* tests/tb_door_lock.sv */
`timescale 1ns/1ns

module tb_door_lock;

    import lock_types_pkg::*;
    import lock_regs_pkg::*;

    localparam int DEBOUNCE_CYCLES = 4;
    localparam int BLOCK_CYCLES    = 40;
    localparam int BIP_TICK_CYCLES = 8;

    // Rough length of all tests, lockout and beep wait dominate
    localparam int TEST_CYCLES = 100 + 12 * (USER_SLOTS + 4) + 8 * DEBOUNCE_CYCLES
                                 + BLOCK_CYCLES + 2 * BIP_TICK_CYCLES;
    localparam int MAX_CYCLES  = 2 * TEST_CYCLES;

    localparam code_t USER_CODE    = 32'h1234_5678;
    localparam code_t TIMEOUT_CODE = 32'hFFFF_FFFE;     // Digit 0 is E

    logic        clk, rst, door_sensor, inside_button, code_valid;
    code_t       code_in;
    logic        wb_cyc, wb_stb, wb_we, wb_ack;
    logic [2:0]  wb_adr;
    logic [31:0] wb_dat_w, wb_dat_r;
    logic        lock_bolt, keypad_en, bip;
    display_t    display;

    // Expected lock state as seen from outside
    logic exp_bolt, exp_keypad, exp_blocked;
    int   exp_attempts;

    int          checks, errors, test_start_errors, cycle_cnt;
    string       test_name;
    logic [31:0] lcg_state = 32'd48;
    logic [31:0] rd_data;
    event        compare_ev;

    door_lock_top #(
        .DEBOUNCE_CYCLES(DEBOUNCE_CYCLES),
        .BLOCK_CYCLES   (BLOCK_CYCLES),
        .BIP_TICK_CYCLES(BIP_TICK_CYCLES)
    ) i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("Timeout: no result after %0d cycles", MAX_CYCLES);
            $display("Verification failed");
            $finish;
        end
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    // Skips codes the FSM treats as special and the stored code
    function automatic code_t random_wrong_code();
        code_t c;
        do begin
            c = lcg_next();
        end while (c[0] == DIGIT_TIMEOUT || c[0] == DIGIT_BLANK || c == USER_CODE);
        return c;
    endfunction

    // One A per failed attempt from digit 0, all A while blocked
    function automatic display_t expected_display(input int attempts, input logic blocked);
        display_t d;
        for (int i = 0; i < DISPLAY_DIGITS; i++) begin
            d[i] = (blocked || i < attempts) ? DIGIT_ERR : DIGIT_BLANK;
        end
        return d;
    endfunction

    function automatic logic [31:0] probe(input string name);
        if (name == "lock_bolt") return 32'(lock_bolt);
        if (name == "keypad_en") return 32'(keypad_en);
        if (name == "bip") return 32'(bip);
        return 32'(display);
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t ns: %s = %h, expected %h", $time, name, got, exp);
        end
    endtask

    always @(compare_ev) begin
        check_value("lock_bolt", 32'(lock_bolt), 32'(exp_bolt));
        check_value("keypad_en", 32'(keypad_en), 32'(exp_keypad));
        check_value("display", 32'(display), 32'(expected_display(exp_attempts, exp_blocked)));
    end

    task automatic check_outputs();
        -> compare_ev;
        #1;
    endtask

    // Polls on the falling edge until the value shows up or time runs out
    task automatic wait_for(input string name, input logic [31:0] exp, input int max_cycles);
        int n;
        n = 0;
        @(negedge clk);
        while (probe(name) !== exp && n < max_cycles) begin
            @(negedge clk);
            n++;
        end
        check_value(name, probe(name), exp);
    endtask

    task automatic hold_check(input string name, input logic [31:0] exp, input int cycles);
        logic [31:0] got;
        got = exp;
        for (int i = 0; i < cycles; i++) begin
            @(negedge clk);
            got = probe(name);
            if (got !== exp) break;
        end
        check_value(name, got, exp);
    endtask

    task automatic wb_access(input logic we, input logic [2:0] adr, input logic [31:0] wdata,
                             output logic [31:0] rdata);
        @(posedge clk);
        wb_cyc   <= 1'b1;
        wb_stb   <= 1'b1;
        wb_we    <= we;
        wb_adr   <= adr;
        wb_dat_w <= wdata;
        do begin
            @(negedge clk);
        end while (!wb_ack);
        rdata = wb_dat_r;
        @(posedge clk);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
    endtask

    task automatic enter_code(input code_t code);
        @(posedge clk);
        code_valid <= 1'b1;
        code_in    <= code;
        @(posedge clk);
        code_valid <= 1'b0;
    endtask

    task automatic press_button(input int cycles);
        @(posedge clk);
        inside_button <= 1'b1;
        repeat (cycles) @(posedge clk);
        inside_button <= 1'b0;
    endtask

    task automatic set_door(input logic open);
        @(posedge clk);
        door_sensor <= open;
    endtask

    task automatic unlock();
        enter_code(USER_CODE);
        wait_for("lock_bolt", 0, USER_SLOTS + 2);
        exp_bolt     = 1'b0;
        exp_keypad   = 1'b0;
        exp_attempts = 0;
        check_outputs();
    endtask

    task automatic relock();
        press_button(DEBOUNCE_CYCLES + 2);
        wait_for("lock_bolt", 1, 4);
        exp_bolt   = 1'b1;
        exp_keypad = 1'b1;
        check_outputs();
    endtask

    task automatic wrong_attempt(input int k);
        enter_code(random_wrong_code());
        exp_attempts = k;
        exp_blocked  = (k >= MAX_ATTEMPTS);
        exp_keypad   = !exp_blocked;
        wait_for("display", 32'(expected_display(exp_attempts, exp_blocked)), USER_SLOTS + 4);
        check_outputs();
    endtask

    task automatic begin_test(input string name);
        test_name         = name;
        test_start_errors = errors;
    endtask

    task automatic end_test();
        if (errors == test_start_errors) begin
            $display("Test %s: ok", test_name);
        end else begin
            $display("Test %s: %0d errors", test_name, errors - test_start_errors);
        end
    endtask

    initial begin
        rst           = 1'b1;
        door_sensor   = 1'b0;
        inside_button = 1'b0;
        code_valid    = 1'b0;
        code_in       = '0;
        wb_cyc        = 1'b0;
        wb_stb        = 1'b0;
        wb_we         = 1'b0;
        wb_adr        = '0;
        wb_dat_w      = '0;
        exp_bolt      = 1'b0;
        exp_keypad    = 1'b0;
        exp_blocked   = 1'b0;
        exp_attempts  = 0;

        begin_test("reset and registers");
        repeat (7) @(posedge clk);
        @(negedge clk);
        check_outputs();                                // Still in reset
        check_value("bip", 32'(bip), 0);
        @(posedge clk);
        rst <= 1'b0;
        wait_for("lock_bolt", 1, 4);
        exp_bolt   = 1'b1;
        exp_keypad = 1'b1;
        check_outputs();
        for (int i = 0; i < USER_SLOTS; i++) begin
            wb_access(1'b0, 3'(i), 0, rd_data);
            check_value("wb_dat_r", rd_data, EMPTY_CODE);
        end
        wb_access(1'b0, REG_BIP_TIME, 0, rd_data);
        check_value("wb_dat_r", rd_data, 32'(BIP_TIME_RESET));
        wb_access(1'b0, REG_ID, 0, rd_data);
        check_value("wb_dat_r", rd_data, LOCK_ID);
        wb_access(1'b1, REG_CODE2, USER_CODE, rd_data);
        wb_access(1'b0, REG_CODE2, 0, rd_data);
        check_value("wb_dat_r", rd_data, USER_CODE);
        end_test();

        begin_test("unlock, open and button");
        unlock();
        set_door(1'b1);
        hold_check("lock_bolt", 0, 3);
        set_door(1'b0);
        hold_check("lock_bolt", 0, 3);
        check_outputs();
        relock();
        press_button(DEBOUNCE_CYCLES - 1);              // Too short for a pulse
        hold_check("lock_bolt", 1, DEBOUNCE_CYCLES + 2);
        check_outputs();
        end_test();

        begin_test("wrong codes below the limit");
        for (int k = 1; k < MAX_ATTEMPTS; k++) begin
            wrong_attempt(k);
        end
        unlock();
        relock();
        end_test();

        begin_test("lockout");
        for (int k = 1; k <= MAX_ATTEMPTS; k++) begin
            wrong_attempt(k);
        end
        wait_for("display", 32'(expected_display(0, 1'b0)), BLOCK_CYCLES + 4);
        exp_blocked  = 1'b0;
        exp_attempts = 0;
        exp_keypad   = 1'b1;
        check_outputs();
        end_test();

        begin_test("keypad timeout beep");
        enter_code(TIMEOUT_CODE);
        @(negedge clk);
        check_value("bip", 32'(bip), 1);
        check_value("lock_bolt", 32'(lock_bolt), 1);
        hold_check("bip", 0, 3);
        check_outputs();
        end_test();

        begin_test("open door beep");
        wb_access(1'b1, REG_BIP_TIME, 2, rd_data);
        unlock();
        set_door(1'b1);
        hold_check("bip", 0, 2 * BIP_TICK_CYCLES);
        wait_for("bip", 1, 3);
        set_door(1'b0);
        wait_for("bip", 0, 3);
        relock();
        end_test();

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule
